// File: design/wq_pkg.sv
`default_nettype none

package wq_pkg;

  typedef logic [7:0]   qp_idx_t;
  typedef logic [23:0]  qpn_t;      // qp index zero-extended
  typedef logic [31:0]  ring_idx_t;
  typedef logic [63:0]  addr_t;
  typedef logic [31:0]  len_t;
  typedef logic [15:0]  wr_id_t;
  typedef logic [511:0] axi_data_t; // one 64-byte wqe beat
  typedef logic [39:0]  cq_wb_t;    // qp index above head index

  typedef enum logic [7:0] {
    WQE_OP_WRITE = 8'd0,
    WQE_OP_SEND  = 8'd2,
    WQE_OP_READ  = 8'd4
  } wqe_op_t;

  typedef enum logic [4:0] {
    RC_SEND_FIRST        = 5'd0,
    RC_SEND_MIDDLE       = 5'd1,
    RC_SEND_LAST         = 5'd2,
    RC_SEND_ONLY         = 5'd4,
    RC_RDMA_WRITE_FIRST  = 5'd6,
    RC_RDMA_WRITE_MIDDLE = 5'd7,
    RC_RDMA_WRITE_LAST   = 5'd8,
    RC_RDMA_WRITE_ONLY   = 5'd10,
    RC_RDMA_READ_REQUEST = 5'd12
  } rc_opcode_t;

  // {qp idx, producer idx, head idx, base addr}
  typedef logic [$bits(qp_idx_t)+2*$bits(ring_idx_t)+$bits(addr_t)-1:0] sq_entry_t;

  // field offsets inside the wqe
  localparam int WQE_WR_ID_LSB  = 0;
  localparam int WQE_LADDR_LSB  = 32;
  localparam int WQE_LEN_LSB    = 96;
  localparam int WQE_OP_LSB     = 128;
  localparam int WQE_RADDR_LSB  = 160;
  localparam int WQE_BYTES_LOG2 = 6;

  function automatic logic op_supported(input wqe_op_t op);
    return (op == WQE_OP_WRITE) || (op == WQE_OP_SEND) || (op == WQE_OP_READ);
  endfunction

endpackage

`default_nettype wire

// File: design/wqe_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wqe_if;

  logic            start;        // one-cycle pulse
  wq_pkg::wqe_op_t op;
  wq_pkg::wr_id_t  wr_id;
  wq_pkg::addr_t   local_addr;
  wq_pkg::addr_t   remote_addr;
  wq_pkg::len_t    len;
  logic            done;         // pulse back when all pieces are out

  modport walker (
    output start, op, wr_id, local_addr, remote_addr, len,
    input  done
  );

  modport segmenter (
    input  start, op, wr_id, local_addr, remote_addr, len,
    output done
  );

endinterface

`default_nettype wire

// File: design/sq_doorbell_capture.sv
`timescale 1ns/1ps
`default_nettype none

module sq_doorbell_capture (
  input  wire                       axis_aclk_i,
  input  wire                       axis_rstn_i,

  input  wire                       doorbell_i,
  input  wire wq_pkg::qp_idx_t      qp_idx_i,
  input  wire wq_pkg::ring_idx_t    sq_prod_idx_i,
  input  wire wq_pkg::ring_idx_t    cq_head_idx_i,
  input  wire wq_pkg::addr_t        sq_base_addr_i,

  input  wire                       fifo_not_full_i,
  output logic                      fifo_wr_o,
  output wq_pkg::sq_entry_t         fifo_entry_o
);

  typedef enum logic {CAP_IDLE, CAP_WRITE} cap_state_t;

  cap_state_t state_q;
  logic       capture;

  // doorbells during a pending write or with a full fifo are dropped
  assign capture   = (state_q == CAP_IDLE) && doorbell_i && fifo_not_full_i;
  assign fifo_wr_o = (state_q == CAP_WRITE);

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q <= CAP_IDLE;
    end else begin
      state_q <= capture ? CAP_WRITE : CAP_IDLE;
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (capture) begin
      fifo_entry_o <= {qp_idx_i, sq_prod_idx_i, cq_head_idx_i, sq_base_addr_i};
    end
  end

endmodule

`default_nettype wire

// File: design/sq_entry_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sq_entry_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire                    axis_aclk_i,
  input  wire                    axis_rstn_i,

  input  wire                    wr_i,
  input  wire wq_pkg::sq_entry_t entry_i,
  input  wire                    rd_i,
  output wq_pkg::sq_entry_t      entry_o,
  output logic                   not_full_o,
  output logic                   not_empty_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  wq_pkg::sq_entry_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign not_full_o  = (count_q != CNT_W'(FIFO_DEPTH));
  assign not_empty_o = (count_q != '0);
  assign push        = wr_i && not_full_o;
  assign pop         = rd_i && not_empty_o;
  assign entry_o     = mem[rd_ptr_q]; // head entry, valid while not empty

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= entry_i;
    end
  end

endmodule

`default_nettype wire

// File: design/sq_walker.sv
`timescale 1ns/1ps
`default_nettype none

module sq_walker (
  input  wire                    axis_aclk_i,
  input  wire                    axis_rstn_i,

  output logic                   fifo_rd_o,
  input  wire wq_pkg::sq_entry_t fifo_entry_i,
  input  wire                    fifo_not_empty_i,

  output logic                   axi_arvalid_o,
  output wq_pkg::addr_t          axi_araddr_o,
  input  wire                    axi_arready_i,
  input  wire                    axi_rvalid_i,
  input  wire wq_pkg::axi_data_t axi_rdata_i,
  input  wire                    axi_rlast_i,
  output logic                   axi_rready_o,

  input  wire                    ack_valid_i,
  output logic                   ack_ready_o,

  output wq_pkg::cq_wb_t         cq_wb_o,
  output logic                   cq_wb_valid_o,

  output wq_pkg::qp_idx_t        cur_qp_idx_o,
  wqe_if.walker                  wqe
);

  typedef enum logic [2:0] {
    W_IDLE, W_AR, W_R, W_START, W_SEG, W_ACK, W_WB
  } walk_state_t;

  walk_state_t state_q;
  walk_state_t state_d;

  // fields of the fifo head entry
  wq_pkg::qp_idx_t   ent_qp;
  wq_pkg::ring_idx_t ent_prod;
  wq_pkg::ring_idx_t ent_head;
  wq_pkg::addr_t     ent_base;

  wq_pkg::qp_idx_t   qp_q;
  wq_pkg::ring_idx_t prod_q;
  wq_pkg::addr_t     base_q;
  wq_pkg::ring_idx_t idx_q;   // slot being worked on
  wq_pkg::ring_idx_t idx_d;
  logic              take_entry;
  logic              take_wqe;

  assign {ent_qp, ent_prod, ent_head, ent_base} = fifo_entry_i;

  assign axi_araddr_o = base_q + (wq_pkg::addr_t'(idx_q) << wq_pkg::WQE_BYTES_LOG2);
  assign cq_wb_o      = {qp_q, idx_q};
  assign cur_qp_idx_o = qp_q;

  //////////////////////////////
  // walker fsm
  //////////////////////////////

  always_comb begin
    state_d       = state_q;
    idx_d         = idx_q;
    fifo_rd_o     = 1'b0;
    axi_arvalid_o = 1'b0;
    axi_rready_o  = 1'b0;
    ack_ready_o   = 1'b0;
    cq_wb_valid_o = 1'b0;
    wqe.start     = 1'b0;
    take_entry    = 1'b0;
    take_wqe      = 1'b0;

    case (state_q)
      W_IDLE: begin
        if (fifo_not_empty_i) begin
          fifo_rd_o  = 1'b1;
          take_entry = 1'b1;
          idx_d      = ent_head;
          if (ent_prod > ent_head) begin
            state_d = W_AR;
          end
        end
      end
      W_AR: begin
        axi_arvalid_o = 1'b1;
        if (axi_arready_i) state_d = W_R;
      end
      W_R: begin
        axi_rready_o = 1'b1;
        if (axi_rvalid_i && axi_rlast_i) begin
          take_wqe = 1'b1;
          state_d  = W_START;
        end
      end
      W_START: begin
        wqe.start = 1'b1;
        state_d   = W_SEG;
      end
      W_SEG: begin
        if (wqe.done) begin
          if (wq_pkg::op_supported(wqe.op)) begin
            state_d = W_ACK;
          end else begin
            idx_d   = idx_q + 1'b1; // nothing sent, no ack to wait for
            state_d = W_WB;
          end
        end
      end
      W_ACK: begin
        if (ack_valid_i) begin
          ack_ready_o = 1'b1;
          idx_d       = idx_q + 1'b1;
          state_d     = W_WB;
        end
      end
      W_WB: begin
        cq_wb_valid_o = 1'b1;
        state_d       = (idx_q < prod_q) ? W_AR : W_IDLE;
      end
      default: state_d = W_IDLE;
    endcase
  end

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q <= W_IDLE;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (take_entry) begin
      qp_q   <= ent_qp;
      prod_q <= ent_prod;
      base_q <= ent_base;
    end
    if (take_wqe) begin   // held until the segmenter is done
      wqe.op          <= wq_pkg::wqe_op_t'(axi_rdata_i[wq_pkg::WQE_OP_LSB +: 8]);
      wqe.wr_id       <= axi_rdata_i[wq_pkg::WQE_WR_ID_LSB +: $bits(wq_pkg::wr_id_t)];
      wqe.local_addr  <= axi_rdata_i[wq_pkg::WQE_LADDR_LSB +: $bits(wq_pkg::addr_t)];
      wqe.remote_addr <= axi_rdata_i[wq_pkg::WQE_RADDR_LSB +: $bits(wq_pkg::addr_t)];
      wqe.len         <= axi_rdata_i[wq_pkg::WQE_LEN_LSB +: $bits(wq_pkg::len_t)];
    end
  end

endmodule

`default_nettype wire

// File: design/wqe_segmenter.sv
`timescale 1ns/1ps
`default_nettype none

module wqe_segmenter #(
  parameter int MTU_BYTES = 4096
) (
  input  wire                 axis_aclk_i,
  input  wire                 axis_rstn_i,

  wqe_if.segmenter            wqe,
  input  wire wq_pkg::qpn_t   qpn_i,

  output logic                req_valid_o,
  input  wire                 req_ready_i,
  output wq_pkg::rc_opcode_t  req_opcode_o,
  output wq_pkg::qpn_t        req_qpn_o,
  output logic                req_last_o,
  output wq_pkg::addr_t       req_remote_addr_o,
  output wq_pkg::addr_t       req_local_addr_o,
  output wq_pkg::len_t        req_len_o
);

  localparam wq_pkg::len_t MTU_LEN = wq_pkg::len_t'(MTU_BYTES);

  typedef enum logic {SEG_IDLE, SEG_VALID} seg_state_t;

  seg_state_t    state_q;
  logic          done_q;
  wq_pkg::len_t  rem_q;     // bytes left after the current piece
  wq_pkg::addr_t laddr_q;
  wq_pkg::addr_t raddr_q;

  logic          first;
  logic          is_read;
  logic          is_send;
  wq_pkg::len_t  src_len;
  wq_pkg::addr_t src_laddr;
  wq_pkg::addr_t src_raddr;
  logic          piece_last;
  wq_pkg::len_t  piece_len;
  logic          load_piece;

  function automatic wq_pkg::rc_opcode_t pick_opcode(
    input wq_pkg::wqe_op_t op,
    input logic            first_piece,
    input logic            last_piece
  );
    wq_pkg::rc_opcode_t opc;
    if (op == wq_pkg::WQE_OP_SEND) begin
      case ({first_piece, last_piece})
        2'b11:   opc = wq_pkg::RC_SEND_ONLY;
        2'b10:   opc = wq_pkg::RC_SEND_FIRST;
        2'b01:   opc = wq_pkg::RC_SEND_LAST;
        default: opc = wq_pkg::RC_SEND_MIDDLE;
      endcase
    end else if (op == wq_pkg::WQE_OP_WRITE) begin
      case ({first_piece, last_piece})
        2'b11:   opc = wq_pkg::RC_RDMA_WRITE_ONLY;
        2'b10:   opc = wq_pkg::RC_RDMA_WRITE_FIRST;
        2'b01:   opc = wq_pkg::RC_RDMA_WRITE_LAST;
        default: opc = wq_pkg::RC_RDMA_WRITE_MIDDLE;
      endcase
    end else begin
      opc = wq_pkg::RC_RDMA_READ_REQUEST;
    end
    return opc;
  endfunction

  //////////////////////////////
  // next piece
  //////////////////////////////

  always_comb begin
    first      = (state_q == SEG_IDLE); // first piece comes straight from the wqe
    is_read    = (wqe.op == wq_pkg::WQE_OP_READ);
    is_send    = (wqe.op == wq_pkg::WQE_OP_SEND);
    src_len    = first ? wqe.len : rem_q;
    src_laddr  = first ? wqe.local_addr : laddr_q;
    src_raddr  = is_send ? '0 : (first ? wqe.remote_addr : raddr_q);
    piece_last = is_read || (src_len <= MTU_LEN); // read never splits
    piece_len  = piece_last ? src_len : MTU_LEN;
    load_piece = first ? (wqe.start && wq_pkg::op_supported(wqe.op))
                       : (req_ready_i && !req_last_o);
  end

  assign req_valid_o = (state_q == SEG_VALID);
  assign req_qpn_o   = qpn_i;
  assign wqe.done    = done_q;

  always_ff @(posedge axis_aclk_i or negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q <= SEG_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        SEG_IDLE: begin
          if (wqe.start) begin
            if (wq_pkg::op_supported(wqe.op)) begin
              state_q <= SEG_VALID;
            end else begin
              done_q <= 1'b1;   // unknown op, no request
            end
          end
        end
        SEG_VALID: begin
          if (req_ready_i && req_last_o) begin
            state_q <= SEG_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= SEG_IDLE;
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (load_piece) begin
      req_opcode_o      <= pick_opcode(wqe.op, first, piece_last);
      req_last_o        <= piece_last;
      req_len_o         <= piece_len;
      req_local_addr_o  <= src_laddr;
      req_remote_addr_o <= src_raddr;
      rem_q             <= src_len - piece_len;
      laddr_q           <= src_laddr + wq_pkg::addr_t'(MTU_BYTES);
      raddr_q           <= src_raddr + wq_pkg::addr_t'(MTU_BYTES);
    end
  end

endmodule

`default_nettype wire

// File: design/wq_manager_top.sv
`timescale 1ns/1ps
`default_nettype none

module wq_manager_top #(
  parameter int MTU_BYTES  = 4096,
  parameter int FIFO_DEPTH = 8
) (
  input  wire                    axis_aclk_i,
  input  wire                    axis_rstn_i,

  // doorbell
  input  wire                    doorbell_i,
  input  wire wq_pkg::qp_idx_t   qp_idx_i,
  input  wire wq_pkg::ring_idx_t sq_prod_idx_i,
  input  wire wq_pkg::ring_idx_t cq_head_idx_i,
  input  wire wq_pkg::addr_t     sq_base_addr_i,

  // axi read, wqe fetch
  output logic                   axi_arvalid_o,
  output wq_pkg::addr_t          axi_araddr_o,
  input  wire                    axi_arready_i,
  input  wire                    axi_rvalid_i,
  input  wire wq_pkg::axi_data_t axi_rdata_i,
  input  wire                    axi_rlast_i,
  output logic                   axi_rready_o,

  // transport requests
  output logic                   sq_req_valid_o,
  input  wire                    sq_req_ready_i,
  output wq_pkg::rc_opcode_t     sq_req_opcode_o,
  output wq_pkg::qpn_t           sq_req_qpn_o,
  output logic                   sq_req_last_o,
  output wq_pkg::addr_t          sq_req_remote_addr_o,
  output wq_pkg::addr_t          sq_req_local_addr_o,
  output wq_pkg::len_t           sq_req_len_o,

  input  wire                    ack_valid_i,
  output logic                   ack_ready_o,

  output wq_pkg::cq_wb_t         cq_wb_o,
  output logic                   cq_wb_valid_o
);

  logic              fifo_wr;
  logic              fifo_rd;
  logic              fifo_not_full;
  logic              fifo_not_empty;
  wq_pkg::sq_entry_t wr_entry;
  wq_pkg::sq_entry_t rd_entry;
  wq_pkg::qp_idx_t   cur_qp_idx;

  wqe_if wqe_bus ();

  sq_doorbell_capture capture_i (
    .axis_aclk_i, .axis_rstn_i,
    .doorbell_i, .qp_idx_i, .sq_prod_idx_i, .cq_head_idx_i, .sq_base_addr_i,
    .fifo_not_full_i (fifo_not_full),
    .fifo_wr_o       (fifo_wr),
    .fifo_entry_o    (wr_entry)
  );

  sq_entry_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
    .axis_aclk_i, .axis_rstn_i,
    .wr_i        (fifo_wr),
    .entry_i     (wr_entry),
    .rd_i        (fifo_rd),
    .entry_o     (rd_entry),
    .not_full_o  (fifo_not_full),
    .not_empty_o (fifo_not_empty)
  );

  sq_walker walker_i (
    .axis_aclk_i, .axis_rstn_i,
    .fifo_rd_o        (fifo_rd),
    .fifo_entry_i     (rd_entry),
    .fifo_not_empty_i (fifo_not_empty),
    .axi_arvalid_o, .axi_araddr_o, .axi_arready_i,
    .axi_rvalid_i, .axi_rdata_i, .axi_rlast_i, .axi_rready_o,
    .ack_valid_i, .ack_ready_o,
    .cq_wb_o, .cq_wb_valid_o,
    .cur_qp_idx_o     (cur_qp_idx),
    .wqe              (wqe_bus.walker)
  );

  wqe_segmenter #(.MTU_BYTES(MTU_BYTES)) segmenter_i (
    .axis_aclk_i, .axis_rstn_i,
    .wqe               (wqe_bus.segmenter),
    .qpn_i             (wq_pkg::qpn_t'(cur_qp_idx)),  // zero-extended
    .req_valid_o       (sq_req_valid_o),
    .req_ready_i       (sq_req_ready_i),
    .req_opcode_o      (sq_req_opcode_o),
    .req_qpn_o         (sq_req_qpn_o),
    .req_last_o        (sq_req_last_o),
    .req_remote_addr_o (sq_req_remote_addr_o),
    .req_local_addr_o  (sq_req_local_addr_o),
    .req_len_o         (sq_req_len_o)
  );

endmodule

`default_nettype wire

// File: verification/tb_wq_manager.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wq_manager;

  localparam int CLK_PERIOD = 40;
  localparam int MTU        = 4096;
  localparam int NUM_WQES   = 6;
  localparam int NUM_REQS   = 10;
  localparam int ITEM_BUDGET = 100; // cycles allowed per wqe or request
  localparam longint WATCHDOG_NS = (NUM_WQES + NUM_REQS + 40) * ITEM_BUDGET * CLK_PERIOD;

  typedef struct packed {
    logic [4:0]  opcode;
    logic [23:0] qpn;
    logic        last;
    logic [63:0] raddr;
    logic [63:0] laddr;
    logic [31:0] len;
  } req_t;

  logic              axis_aclk;
  logic              axis_rstn;
  logic              doorbell;
  wq_pkg::qp_idx_t   qp_idx;
  wq_pkg::ring_idx_t sq_prod_idx;
  wq_pkg::ring_idx_t cq_head_idx;
  wq_pkg::addr_t     sq_base_addr;
  logic              axi_arvalid;
  wq_pkg::addr_t     axi_araddr;
  logic              axi_arready;
  logic              axi_rvalid;
  wq_pkg::axi_data_t axi_rdata;
  logic              axi_rlast;
  logic              axi_rready;
  logic              sq_req_valid;
  logic              sq_req_ready;
  wq_pkg::rc_opcode_t sq_req_opcode;
  wq_pkg::qpn_t      sq_req_qpn;
  logic              sq_req_last;
  wq_pkg::addr_t     sq_req_remote_addr;
  wq_pkg::addr_t     sq_req_local_addr;
  wq_pkg::len_t      sq_req_len;
  logic              ack_valid;
  logic              ack_ready;
  wq_pkg::cq_wb_t    cq_wb;
  logic              cq_wb_valid;

  wq_pkg::axi_data_t wqe_mem [wq_pkg::addr_t];
  wq_pkg::addr_t     exp_araddr [$];
  req_t              exp_req [$];
  wq_pkg::cq_wb_t    exp_wb [$];

  int unsigned checks;
  int unsigned errors;
  int unsigned seed_val;
  logic        rd_pending;
  int unsigned rd_wait;
  logic        ack_armed;
  int unsigned ack_wait;
  logic        ack_seen;
  logic        hold_valid;
  req_t        held_req;
  req_t        cur_req;
  req_t        want;

  wq_manager_top #(.MTU_BYTES(MTU), .FIFO_DEPTH(8)) dut_i (
    .axis_aclk_i (axis_aclk), .axis_rstn_i (axis_rstn),
    .doorbell_i (doorbell), .qp_idx_i (qp_idx), .sq_prod_idx_i (sq_prod_idx),
    .cq_head_idx_i (cq_head_idx), .sq_base_addr_i (sq_base_addr),
    .axi_arvalid_o (axi_arvalid), .axi_araddr_o (axi_araddr), .axi_arready_i (axi_arready),
    .axi_rvalid_i (axi_rvalid), .axi_rdata_i (axi_rdata), .axi_rlast_i (axi_rlast),
    .axi_rready_o (axi_rready),
    .sq_req_valid_o (sq_req_valid), .sq_req_ready_i (sq_req_ready),
    .sq_req_opcode_o (sq_req_opcode), .sq_req_qpn_o (sq_req_qpn),
    .sq_req_last_o (sq_req_last), .sq_req_remote_addr_o (sq_req_remote_addr),
    .sq_req_local_addr_o (sq_req_local_addr), .sq_req_len_o (sq_req_len),
    .ack_valid_i (ack_valid), .ack_ready_o (ack_ready),
    .cq_wb_o (cq_wb), .cq_wb_valid_o (cq_wb_valid)
  );

  initial begin
    axis_aclk = 1'b0;
    forever #(CLK_PERIOD / 2) axis_aclk = ~axis_aclk;
  end

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // expected transport requests for one wqe
  task automatic push_pieces(input wq_pkg::qp_idx_t qp, input logic [7:0] op,
                             input wq_pkg::len_t len, input wq_pkg::addr_t laddr,
                             input wq_pkg::addr_t raddr);
    req_t         r;
    wq_pkg::len_t left;
    logic         first;
    r.qpn   = {16'h0, qp};
    r.laddr = laddr;
    r.raddr = (op == wq_pkg::WQE_OP_SEND) ? '0 : raddr;
    left    = len;
    first   = 1'b1;
    if (op == wq_pkg::WQE_OP_READ) begin
      r.opcode = wq_pkg::RC_RDMA_READ_REQUEST;
      r.last   = 1'b1;
      r.len    = len;
      exp_req.push_back(r);
    end else begin
      do begin
        r.last = (left <= MTU);
        r.len  = r.last ? left : MTU;
        if (op == wq_pkg::WQE_OP_SEND) begin
          r.opcode = (first && r.last) ? wq_pkg::RC_SEND_ONLY :
                     first ? wq_pkg::RC_SEND_FIRST :
                     r.last ? wq_pkg::RC_SEND_LAST : wq_pkg::RC_SEND_MIDDLE;
        end else begin
          r.opcode = (first && r.last) ? wq_pkg::RC_RDMA_WRITE_ONLY :
                     first ? wq_pkg::RC_RDMA_WRITE_FIRST :
                     r.last ? wq_pkg::RC_RDMA_WRITE_LAST : wq_pkg::RC_RDMA_WRITE_MIDDLE;
        end
        exp_req.push_back(r);
        left  = left - r.len;
        r.laddr = r.laddr + MTU;
        if (op != wq_pkg::WQE_OP_SEND) r.raddr = r.raddr + MTU;
        first = 1'b0;
      end while (!r.last);
    end
  endtask

  task automatic load_wqe(input wq_pkg::qp_idx_t qp, input wq_pkg::addr_t base,
                          input wq_pkg::ring_idx_t idx, input logic [7:0] op,
                          input wq_pkg::len_t len, input wq_pkg::addr_t laddr,
                          input wq_pkg::addr_t raddr, input wq_pkg::wr_id_t wr_id);
    wq_pkg::axi_data_t beat;
    wq_pkg::addr_t     slot;
    beat = '0;
    beat[wq_pkg::WQE_WR_ID_LSB +: 16] = wr_id;
    beat[wq_pkg::WQE_LADDR_LSB +: 64] = laddr;
    beat[wq_pkg::WQE_LEN_LSB   +: 32] = len;
    beat[wq_pkg::WQE_OP_LSB    +: 8]  = op;
    beat[wq_pkg::WQE_RADDR_LSB +: 64] = raddr;
    slot = base + idx * 64;
    wqe_mem[slot] = beat;
    exp_araddr.push_back(slot);
    push_pieces(qp, op, len, laddr, raddr);
    exp_wb.push_back({qp, idx + 32'd1});
  endtask

  task automatic ring_doorbell(input wq_pkg::qp_idx_t qp, input wq_pkg::ring_idx_t prod,
                               input wq_pkg::ring_idx_t head, input wq_pkg::addr_t base);
    @(posedge axis_aclk);
    doorbell     <= 1'b1;
    qp_idx       <= qp;
    sq_prod_idx  <= prod;
    cq_head_idx  <= head;
    sq_base_addr <= base;
    @(posedge axis_aclk);
    doorbell <= 1'b0;
    @(posedge axis_aclk); // capture stage busy this cycle
  endtask

  task automatic wait_drained();
    while (exp_araddr.size() + exp_req.size() + exp_wb.size() != 0) @(posedge axis_aclk);
    repeat (20) @(posedge axis_aclk);
  endtask

  //////////////////////////////
  // axi read responder
  //////////////////////////////

  always @(posedge axis_aclk) begin
    if (!axis_rstn) begin
      axi_arready <= 1'b0;
      axi_rvalid  <= 1'b0;
      axi_rlast   <= 1'b0;
      rd_pending  <= 1'b0;
    end else begin
      if (axi_arvalid && axi_arready) begin
        axi_arready <= 1'b0;
        checks++;
        assert (exp_araddr.size() != 0) else begin
          errors++;
          $display("AXI read issued with no fetch expected, address 0x%0h", axi_araddr);
        end
        if (exp_araddr.size() != 0) begin
          compare_field("axi_araddr_o", axi_araddr, exp_araddr.pop_front());
        end
        checks++;
        assert (wqe_mem.exists(axi_araddr)) else begin
          errors++;
          $display("AXI read of an unloaded WQE slot at 0x%0h", axi_araddr);
        end
        axi_rdata  <= wqe_mem.exists(axi_araddr) ? wqe_mem[axi_araddr] : '0;
        rd_pending <= 1'b1;
        rd_wait    <= $urandom % 5;
      end else if (axi_arvalid) begin
        axi_arready <= ($urandom % 3 == 0);
      end
      if (axi_rvalid && axi_rready) begin
        axi_rvalid <= 1'b0;
        axi_rlast  <= 1'b0;
      end else if (rd_pending && !axi_rvalid) begin
        if (rd_wait != 0) begin
          rd_wait <= rd_wait - 1;
        end else begin
          axi_rvalid <= 1'b1;
          axi_rlast  <= 1'b1; // single beat
          rd_pending <= 1'b0;
        end
      end
    end
  end

  // random back-pressure and ack delay
  always @(posedge axis_aclk) begin
    if (!axis_rstn) begin
      sq_req_ready <= 1'b0;
      ack_valid    <= 1'b0;
      ack_armed    <= 1'b0;
    end else begin
      sq_req_ready <= ($urandom % 2 == 1);
      if (ack_valid && ack_ready) begin
        ack_valid <= 1'b0;
      end else if (ack_armed) begin
        if (ack_wait != 0) begin
          ack_wait <= ack_wait - 1;
        end else begin
          ack_valid <= 1'b1;
          ack_armed <= 1'b0;
        end
      end
      if (sq_req_valid && sq_req_ready && sq_req_last) begin
        ack_armed <= 1'b1;
        ack_wait  <= $urandom % 6;
      end
    end
  end

  //////////////////////////////
  // monitors
  //////////////////////////////

  always @(posedge axis_aclk) begin
    cur_req = {sq_req_opcode, sq_req_qpn, sq_req_last, sq_req_remote_addr,
               sq_req_local_addr, sq_req_len};
    if (!axis_rstn) begin
      hold_valid <= 1'b0;
      ack_seen   <= 1'b0;
    end else begin
      if (hold_valid) begin  // stalled request must not move
        compare_field("sq_req_valid_o", sq_req_valid, 1'b1);
        compare_field("sq_req_opcode_o", sq_req_opcode, held_req.opcode);
        compare_field("sq_req_qpn_o", sq_req_qpn, held_req.qpn);
        compare_field("sq_req_last_o", sq_req_last, held_req.last);
        compare_field("sq_req_remote_addr_o", sq_req_remote_addr, held_req.raddr);
        compare_field("sq_req_local_addr_o", sq_req_local_addr, held_req.laddr);
        compare_field("sq_req_len_o", sq_req_len, held_req.len);
      end
      hold_valid <= sq_req_valid && !sq_req_ready;
      held_req   <= cur_req;
      if (sq_req_valid && sq_req_ready) begin
        checks++;
        assert (exp_req.size() != 0) else begin
          errors++;
          $display("transport request sent with none expected");
        end
        if (exp_req.size() != 0) begin
          want = exp_req.pop_front();
          compare_field("sq_req_opcode_o", sq_req_opcode, want.opcode);
          compare_field("sq_req_qpn_o", sq_req_qpn, want.qpn);
          compare_field("sq_req_last_o", sq_req_last, want.last);
          compare_field("sq_req_remote_addr_o", sq_req_remote_addr, want.raddr);
          compare_field("sq_req_local_addr_o", sq_req_local_addr, want.laddr);
          compare_field("sq_req_len_o", sq_req_len, want.len);
        end
      end
      if (cq_wb_valid) begin
        checks++;
        assert (ack_seen) else begin
          errors++;
          $display("completion writeback without a preceding acknowledge");
        end
        checks++;
        assert (exp_wb.size() != 0) else begin
          errors++;
          $display("completion writeback with none expected");
        end
        if (exp_wb.size() != 0) begin
          compare_field("cq_wb_o", cq_wb, exp_wb.pop_front());
        end
        ack_seen <= 1'b0;
      end
      if (ack_valid && ack_ready) ack_seen <= 1'b1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all transfers completed");
    $display("checks run: %0d, errors: %0d", checks, errors + 1);
    $display("test failed");
    $finish;
  end

  initial begin
    seed_val     = $urandom(32'hf3c21701);
    checks       = 0;
    errors       = 0;
    axis_rstn    = 1'b0;
    doorbell     = 1'b0;
    qp_idx       = '0;
    sq_prod_idx  = '0;
    cq_head_idx  = '0;
    sq_base_addr = '0;
    axi_arready  = 1'b0;
    axi_rvalid   = 1'b0;
    axi_rdata    = '0;
    axi_rlast    = 1'b0;
    sq_req_ready = 1'b0;
    ack_valid    = 1'b0;

    repeat (2) @(posedge axis_aclk);
    compare_field("sq_req_valid_o", sq_req_valid, 1'b0);
    compare_field("axi_arvalid_o", axi_arvalid, 1'b0);
    compare_field("axi_rready_o", axi_rready, 1'b0);
    compare_field("ack_ready_o", ack_ready, 1'b0);
    compare_field("cq_wb_valid_o", cq_wb_valid, 1'b0);
    axis_rstn <= 1'b1;

    // write split in three then a one mtu send and an unsplit read
    load_wqe(8'd3, 64'h1000_0000, 0, wq_pkg::WQE_OP_WRITE, 10000, 64'h2000, 64'h9000_0000, 16'h11);
    load_wqe(8'd3, 64'h1000_0000, 1, wq_pkg::WQE_OP_SEND, 4096, 64'h8000, 64'h7777_0000, 16'h12);
    load_wqe(8'd3, 64'h1000_0000, 2, wq_pkg::WQE_OP_READ, 9000, 64'hc000, 64'h5000_0000, 16'h13);
    ring_doorbell(8'd3, 3, 0, 64'h1000_0000);
    // empty rings make no traffic
    ring_doorbell(8'd5, 4, 4, 64'h4000_0000);
    ring_doorbell(8'd6, 2, 7, 64'h4000_0000);
    wait_drained();

    // two doorbells queued behind each other
    load_wqe(8'd7, 64'h2000_0000, 10, wq_pkg::WQE_OP_WRITE, 4096, 64'h1_0000, 64'h6000_0000, 16'h21);
    load_wqe(8'd7, 64'h2000_0000, 11, wq_pkg::WQE_OP_SEND, 5000, 64'h2_0000, 64'h6100_0000, 16'h22);
    load_wqe(8'd9, 64'h3000_0000, 1, wq_pkg::WQE_OP_WRITE, 8192, 64'h3_0000, 64'h6200_0000, 16'h31);
    ring_doorbell(8'd7, 12, 10, 64'h2000_0000);
    ring_doorbell(8'd9, 2, 1, 64'h3000_0000);
    wait_drained();

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
design/wq_pkg.sv
design/wqe_if.sv
design/sq_doorbell_capture.sv
design/sq_entry_fifo.sv
design/sq_walker.sv
design/wqe_segmenter.sv
design/wq_manager_top.sv
verification/tb_wq_manager.sv

// File: Bender.yml
package:
  name: wq_manager

sources:
  - files:
      - design/wq_pkg.sv
      - design/wqe_if.sv
      - design/sq_doorbell_capture.sv
      - design/sq_entry_fifo.sv
      - design/sq_walker.sv
      - design/wqe_segmenter.sv
      - design/wq_manager_top.sv
  - target: test
    files:
      - verification/tb_wq_manager.sv
